// ==== src/rdreq_pkg.sv ====
/*
 * shared types for the pcie memory-read request issuer
 * 4dw mrd64 header only, tags are 5 bits and wrap modulo 32
 * beat layout puts header dw0 in the low 32 bits of the word
 */
package rdreq_pkg;

    //////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////
    localparam int TAG_W    = 5;
    localparam int ADDR_W   = 64;
    localparam int LEN_W    = 13;   // up to 4096 bytes
    localparam int DW_LEN_W = 10;
    localparam int REQ_ID_W = 16;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [DW_LEN_W-1:0] dw_len_t;
    typedef logic [REQ_ID_W-1:0] req_id_t;

    // fmt 001 (4dw no data) type 00000
    localparam logic [7:0] MRD64_FMT_TYPE = 8'h20;

    //////////////////////////////////////////////////////////////
    // tlp header, msb first so dw3 sits on top
    //////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [29:0] addr_lo;   // dw3 address bits 31:2
        logic [1:0]  rsvd_a;
        logic [31:0] addr_hi;   // dw2
        req_id_t     req_id;    // dw1
        logic [2:0]  rsvd_tag;  // upper tag bits unused
        tag_t        tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
        logic [7:0]  fmt_type;  // dw0
        logic [13:0] rsvd0;     // tc td ep attr all zero
        dw_len_t     length;
    } rd_hdr_t;

    // header fields on the channel side, raw dwords on the endpoint side
    typedef union packed {
        rd_hdr_t          hdr;
        logic [3:0][31:0] dw;
    } tlp_beat_u;

endpackage

// ==== src/rdreq_ifs.sv ====
/*
 * arbitration and header beat interfaces between channels,
 * arbiter and transmit merge. no ready signal anywhere
 */
`timescale 1ns/10ps

//////////////////////////////////////////////////////////////
// channel <-> arbiter
//////////////////////////////////////////////////////////////
interface arb_if;

    logic trn;      // grant pulse, drive next cycle
    logic reqep;    // level, chunk pending
    logic drvn;     // level, channel owns the tx beat
    logic tag_inc;  // pulse, tag consumed

    modport arb (
        output trn,
        input  reqep,
        input  drvn,
        input  tag_inc
    );

    modport chn (
        input  trn,
        output reqep,
        output drvn,
        output tag_inc
    );

endinterface

//////////////////////////////////////////////////////////////
// channel -> tx merge
//////////////////////////////////////////////////////////////
interface tlp_if;

    logic                  valid;
    logic                  sop;
    logic                  eop;
    rdreq_pkg::tlp_beat_u  beat;   // one 4dw header per beat

    modport src (output valid, output sop, output eop, output beat);

    modport dst (input valid, input sop, input eop, input beat);

endinterface

// ==== src/chn_req.sv ====
/*
 * one dma channel splitting a read command into mrd64 tlps
 * command must be aligned to MAX_RD_REQ, no 4k split is done
 * length is expected in whole dwords, a ragged tail is rounded up
 * a strobe while cmd_busy is high is dropped
 */
`timescale 1ns/10ps

module chn_req #(
    parameter int MAX_RD_REQ = 128   // bytes, 64..512
) (
    input  logic                clk,
    input  logic                rst,

    // command side
    input  logic                cmd_valid,
    input  rdreq_pkg::addr_t    cmd_addr,
    input  rdreq_pkg::len_t     cmd_len,
    output logic                cmd_busy,

    // header constants
    input  rdreq_pkg::req_id_t  req_id,
    input  rdreq_pkg::tag_t     tag,      // shared counter from arbiter

    arb_if.chn                  arb,
    tlp_if.src                  tx
);

    localparam rdreq_pkg::len_t MAX_LEN = rdreq_pkg::len_t'(MAX_RD_REQ);

    //////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////
    logic                  busy_q;
    logic                  reqep_q;
    logic                  drv_q;      // high on the beat cycle only
    rdreq_pkg::len_t       rem_len;    // bytes still to request
    rdreq_pkg::addr_t      nxt_addr;   // address of next chunk
    rdreq_pkg::len_t       chunk_len;
    rdreq_pkg::dw_len_t    chunk_dw;
    rdreq_pkg::rd_hdr_t    hdr_nxt;
    rdreq_pkg::tlp_beat_u  beat_q;

    // chunk is a full max request or whatever is left
    assign chunk_len = (rem_len > MAX_LEN) ? MAX_LEN : rem_len;
    assign chunk_dw  = rdreq_pkg::dw_len_t'((chunk_len + 13'd3) >> 2);

    //////////////////////////////////////////////////////////////
    // command latch and chunk bookkeeping
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            reqep_q <= 1'b0;
            drv_q   <= 1'b0;
            rem_len <= '0;
        end else begin
            drv_q <= 1'b0;   // beat lasts one cycle

            if (!busy_q) begin
                // new command, zero length is ignored
                if (cmd_valid && (cmd_len != '0)) begin
                    busy_q   <= 1'b1;
                    reqep_q  <= 1'b1;
                    rem_len  <= cmd_len;
                    nxt_addr <= cmd_addr;
                end
            end else if (arb.trn) begin
                // granted, drive the beat next cycle
                reqep_q  <= 1'b0;
                drv_q    <= 1'b1;
                rem_len  <= rem_len - chunk_len;
                nxt_addr <= nxt_addr + rdreq_pkg::addr_t'(chunk_len);
            end else if (drv_q) begin
                // beat is out, ask again if anything left
                reqep_q <= (rem_len != '0);
                busy_q  <= (rem_len != '0);
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // header fields for the current chunk
    //////////////////////////////////////////////////////////////
    always_comb begin
        hdr_nxt          = '0;
        hdr_nxt.fmt_type = rdreq_pkg::MRD64_FMT_TYPE;
        hdr_nxt.length   = chunk_dw;
        hdr_nxt.req_id   = req_id;
        hdr_nxt.tag      = tag;          // value seen on the trn cycle
        hdr_nxt.first_be = 4'hf;
        // single dw request has no last be
        hdr_nxt.last_be  = (chunk_dw == rdreq_pkg::dw_len_t'(1)) ? 4'h0 : 4'hf;
        hdr_nxt.addr_hi  = nxt_addr[63:32];
        hdr_nxt.addr_lo  = nxt_addr[31:2];
    end

    // payload register, loaded with the grant
    always_ff @(posedge clk) begin
        if (arb.trn) begin
            beat_q.hdr <= hdr_nxt;
        end
    end

    //////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////
    assign cmd_busy    = busy_q;

    assign arb.reqep   = reqep_q;
    assign arb.drvn    = drv_q;
    assign arb.tag_inc = drv_q;   // one tag per beat

    // single beat tlp so sop and eop follow valid
    assign tx.valid    = drv_q;
    assign tx.sop      = drv_q;
    assign tx.eop      = drv_q;
    assign tx.beat     = beat_q;

endmodule

// ==== src/chn_arb.sv ====
/*
 * two channel arbiter for the shared tx path
 * alternating priority, chn1 first after reset
 * owns the tag counter, no recycling on completion
 */
`timescale 1ns/10ps

module chn_arb (
    input  logic             clk,
    input  logic             rst,

    output rdreq_pkg::tag_t  tag,   // next free tag

    arb_if.arb               c0,
    arb_if.arb               c1
);

    //////////////////////////////////////////////////////////////
    // fsm encoding, one hot
    //////////////////////////////////////////////////////////////
    localparam logic [4:0] ST_RST   = 5'b00001;
    localparam logic [4:0] ST_IDLE0 = 5'b00010;   // after chn0, prefers chn1
    localparam logic [4:0] ST_GNT0  = 5'b00100;
    localparam logic [4:0] ST_GNT1  = 5'b01000;
    localparam logic [4:0] ST_IDLE1 = 5'b10000;   // after chn1, prefers chn0

    logic [4:0] state;

    //////////////////////////////////////////////////////////////
    // arbitration and tag counter
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_RST;
            c0.trn <= 1'b0;
            c1.trn <= 1'b0;
            tag    <= '0;
        end else begin
            // grants are single cycle
            c0.trn <= 1'b0;
            c1.trn <= 1'b0;

            // only one channel drives per cycle so one inc at most
            if (c0.tag_inc || c1.tag_inc) begin
                tag <= tag + rdreq_pkg::tag_t'(1);
            end

            case (state)
                ST_RST: begin
                    state <= ST_IDLE0;   // so chn1 wins first
                end

                ST_IDLE0: begin
                    if (!c0.drvn) begin   // wait for last beat to clear
                        if (c1.reqep) begin
                            c1.trn <= 1'b1;
                            state  <= ST_GNT1;
                        end else if (c0.reqep) begin
                            c0.trn <= 1'b1;
                            state  <= ST_GNT0;
                        end
                    end
                end

                // hold one cycle while the channel picks up the grant
                ST_GNT0: state <= ST_IDLE0;

                ST_GNT1: state <= ST_IDLE1;

                ST_IDLE1: begin
                    if (!c1.drvn) begin
                        if (c0.reqep) begin
                            c0.trn <= 1'b1;
                            state  <= ST_GNT0;
                        end else if (c1.reqep) begin
                            c1.trn <= 1'b1;
                            state  <= ST_GNT1;
                        end
                    end
                end

                default: state <= ST_RST;
            endcase
        end
    end

endmodule

// ==== src/tx_mux.sv ====
/*
 * registered merge of the channel header beats onto the tx port
 * relies on the arbiter never letting both channels drive at once
 */
`timescale 1ns/10ps

module tx_mux (
    input  logic                  clk,
    input  logic                  rst,

    tlp_if.dst                    c0,
    tlp_if.dst                    c1,

    output logic                  tx_valid,
    output logic                  tx_sop,
    output logic                  tx_eop,
    output rdreq_pkg::tlp_beat_u  tx_data
);

    //////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
            tx_sop   <= 1'b0;
            tx_eop   <= 1'b0;
        end else if (c0.valid) begin
            tx_valid <= 1'b1;
            tx_sop   <= c0.sop;
            tx_eop   <= c0.eop;
        end else if (c1.valid) begin
            tx_valid <= 1'b1;
            tx_sop   <= c1.sop;
            tx_eop   <= c1.eop;
        end else begin
            // idle cycle
            tx_valid <= 1'b0;
            tx_sop   <= 1'b0;
            tx_eop   <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////
    // data, raw dword view
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (c0.valid) begin
            tx_data.dw <= c0.beat.dw;
        end else if (c1.valid) begin
            tx_data.dw <= c1.beat.dw;
        end
    end

endmodule

// ==== src/pcie_rdreq_top.sv ====
/*
 * pcie memory-read request issuer for a two channel dma
 * endpoint must accept every beat, there is no back-pressure
 * commands aligned to MAX_RD_REQ, tags wrap modulo 32
 */
`timescale 1ns/10ps

module pcie_rdreq_top #(
    parameter int MAX_RD_REQ = 128   // bytes, 64..512
) (
    input  logic                  clk,
    input  logic                  rst,
    input  rdreq_pkg::req_id_t    cfg_req_id,

    // channel 0 command
    input  logic                  cmd0_valid,
    input  rdreq_pkg::addr_t      cmd0_addr,
    input  rdreq_pkg::len_t       cmd0_len,
    output logic                  cmd0_busy,

    // channel 1 command
    input  logic                  cmd1_valid,
    input  rdreq_pkg::addr_t      cmd1_addr,
    input  rdreq_pkg::len_t       cmd1_len,
    output logic                  cmd1_busy,

    // endpoint tx
    output logic                  tx_valid,
    output logic                  tx_sop,
    output logic                  tx_eop,
    output rdreq_pkg::tlp_beat_u  tx_data
);

    //////////////////////////////////////////////////////////////
    // internal links
    //////////////////////////////////////////////////////////////
    rdreq_pkg::tag_t tag;   // shared tag from arbiter

    arb_if arb0 ();
    arb_if arb1 ();
    tlp_if tlp0 ();
    tlp_if tlp1 ();

    //////////////////////////////////////////////////////////////
    // channels
    //////////////////////////////////////////////////////////////
    chn_req #(
        .MAX_RD_REQ (MAX_RD_REQ)
    ) chn0_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd0_valid),
        .cmd_addr  (cmd0_addr),
        .cmd_len   (cmd0_len),
        .cmd_busy  (cmd0_busy),
        .req_id    (cfg_req_id),
        .tag       (tag),
        .arb       (arb0.chn),
        .tx        (tlp0.src)
    );

    chn_req #(
        .MAX_RD_REQ (MAX_RD_REQ)
    ) chn1_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd1_valid),
        .cmd_addr  (cmd1_addr),
        .cmd_len   (cmd1_len),
        .cmd_busy  (cmd1_busy),
        .req_id    (cfg_req_id),
        .tag       (tag),
        .arb       (arb1.chn),
        .tx        (tlp1.src)
    );

    //////////////////////////////////////////////////////////////
    // arbiter and tx merge
    //////////////////////////////////////////////////////////////
    chn_arb arb_i (
        .clk (clk),
        .rst (rst),
        .tag (tag),
        .c0  (arb0.arb),
        .c1  (arb1.arb)
    );

    tx_mux mux_i (
        .clk      (clk),
        .rst      (rst),
        .c0       (tlp0.dst),
        .c1       (tlp1.dst),
        .tx_valid (tx_valid),
        .tx_sop   (tx_sop),
        .tx_eop   (tx_eop),
        .tx_data  (tx_data)
    );

endmodule

// ==== verif/rdreq_ref.svh ====
/*
 * expected header model for the read request testbench
 * chunks of MAX_RD_REQ bytes, whole dwords, no 4k split
 * included inside the testbench module, uses its cfg_req_id
 */
`ifndef RDREQ_REF_SVH
`define RDREQ_REF_SVH

rdreq_pkg::rd_hdr_t exp_q0[$];   // chn0 headers in issue order
rdreq_pkg::rd_hdr_t exp_q1[$];
int beats_planned = 0;           // feeds the watchdog budget

// one mrd64 header for a chunk, tag filled in by the monitor
function automatic rdreq_pkg::rd_hdr_t ref_hdr(rdreq_pkg::addr_t addr, int unsigned bytes);
    rdreq_pkg::rd_hdr_t h;
    int unsigned        dws;
    dws        = (bytes + 3) / 4;
    h          = '0;
    h.fmt_type = 8'h20;   // fmt 001 type 00000
    h.length   = rdreq_pkg::dw_len_t'(dws);
    h.req_id   = cfg_req_id;
    h.first_be = 4'hf;
    h.last_be  = (dws == 1) ? 4'h0 : 4'hf;   // single dw has no last be
    h.addr_hi  = addr[63:32];
    h.addr_lo  = addr[31:2];
    return h;
endfunction

// split a command and queue its chunks
task automatic expect_cmd(logic ch, rdreq_pkg::addr_t addr, rdreq_pkg::len_t len);
    int unsigned      left;
    int unsigned      chunk;
    rdreq_pkg::addr_t a;
    left = 32'(len);
    a    = addr;
    while (left > 0) begin
        chunk = (left > MAX_RD_REQ) ? MAX_RD_REQ : left;   // short tail last
        if (ch) exp_q1.push_back(ref_hdr(a, chunk));
        else    exp_q0.push_back(ref_hdr(a, chunk));
        a    = a + rdreq_pkg::addr_t'(chunk);
        left = left - chunk;
        beats_planned++;
    end
endtask

task automatic check_hdr(rdreq_pkg::rd_hdr_t exp, rdreq_pkg::rd_hdr_t act);
    if (act !== exp) begin
        $display("ERR %s hdr: expected %h actual %h", test_name, exp, act);
        fail_run();
    end
endtask

task automatic check_tag(rdreq_pkg::tag_t exp, rdreq_pkg::tag_t act);
    if (act !== exp) begin
        $display("ERR %s tag: expected %0d actual %0d", test_name, exp, act);
        fail_run();
    end
endtask

task automatic check_flag(string what, logic exp, logic act);
    if (act !== exp) begin
        $display("ERR %s %s: expected %b actual %b", test_name, what, exp, act);
        fail_run();
    end
endtask

`endif

// ==== verif/tb_pcie_rdreq.sv ====
/*
 * testbench for the read request issuer at MAX_RD_REQ 128
 * channel of a beat comes from address bit 63, chn1 lives up there
 * inputs change on the falling edge, stops at the first mismatch
 */
`timescale 1ns/10ps

module tb_pcie_rdreq;

    localparam int MAX_RD_REQ = 128;

    logic                 clk = 1'b0;
    logic                 rst;
    rdreq_pkg::req_id_t   cfg_req_id;
    logic                 cmd0_valid, cmd1_valid;
    rdreq_pkg::addr_t     cmd0_addr, cmd1_addr;
    rdreq_pkg::len_t      cmd0_len, cmd1_len;
    logic                 cmd0_busy, cmd1_busy;
    logic                 tx_valid, tx_sop, tx_eop;
    rdreq_pkg::tlp_beat_u tx_data;

    string           test_name = "reset";
    logic            alt_mode  = 1'b0;   // both channels loaded together
    logic            have_prev = 1'b0;
    logic            prev_ch   = 1'b0;
    rdreq_pkg::tag_t exp_tag   = '0;
    int              wd_cycles = 0;

    always #10 clk = ~clk;   // 20 ns period

    pcie_rdreq_top #(.MAX_RD_REQ(MAX_RD_REQ)) pcie_rdreq_top_i (.*);

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    `include "rdreq_ref.svh"

    function automatic rdreq_pkg::addr_t rand_addr(logic ch);
        rdreq_pkg::addr_t a;
        a         = {$urandom, $urandom};
        a[63:40]  = '0;
        a[6:0]    = '0;   // aligned to max request
        a[63]     = ch;   // region marks the channel
        return a;
    endfunction

    // queue the expected chunks, then strobe one or both channels
    task automatic issue(logic v0, rdreq_pkg::len_t l0, logic v1, rdreq_pkg::len_t l1);
        rdreq_pkg::addr_t a0;
        rdreq_pkg::addr_t a1;
        a0 = rand_addr(1'b0);
        a1 = rand_addr(1'b1);
        if (v0) expect_cmd(1'b0, a0, l0);
        if (v1) expect_cmd(1'b1, a1, l1);
        @(negedge clk);
        cmd0_valid = v0;
        cmd0_addr  = a0;
        cmd0_len   = l0;
        cmd1_valid = v1;
        cmd1_addr  = a1;
        cmd1_len   = l1;
        @(negedge clk);
        cmd0_valid = 1'b0;
        cmd1_valid = 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge clk);
        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        void'($urandom(32'h0e87_87ce));
        rst        = 1'b1;
        cmd0_valid = 1'b0;
        cmd1_valid = 1'b0;
        cmd0_addr  = '0;
        cmd1_addr  = '0;
        cmd0_len   = '0;
        cmd1_len   = '0;
        cfg_req_id = rdreq_pkg::req_id_t'($urandom);
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("cmd0_busy", 1'b0, cmd0_busy);
        check_flag("cmd1_busy", 1'b0, cmd1_busy);
        check_flag("tx_valid", 1'b0, tx_valid);

        test_name = "single_split";
        issue(1'b1, rdreq_pkg::len_t'(4 * (($urandom % 1024) + 1)), 1'b0, '0);
        wait_drain();

        test_name = "tag_wrap";   // 32 beats carry the tag past 31
        issue(1'b1, 13'd4096, 1'b0, '0);
        wait_drain();

        test_name = "alternation";
        alt_mode  = 1'b1;
        issue(1'b1, 13'd4096, 1'b1, 13'd2048);
        wait_drain();
        alt_mode  = 1'b0;

        test_name = "short_tail";
        issue(1'b1, 13'd4, 1'b1, 13'd420);   // lone dw and 3 x 128 + 36
        wait_drain();
        issue(1'b1, 13'd132, 1'b0, '0);      // 128 then one dw
        wait_drain();

        test_name = "busy_ignore";
        issue(1'b1, 13'd1024, 1'b0, '0);
        check_flag("cmd0_busy", 1'b1, cmd0_busy);
        repeat (4) @(negedge clk);
        cmd0_valid = 1'b1;   // strobe while busy is dropped
        cmd0_addr  = rand_addr(1'b0);
        cmd0_len   = 13'd256;
        @(negedge clk);
        cmd0_valid = 1'b0;
        wait_drain();
        repeat (30) @(negedge clk);   // room for a stray beat

        test_name = "random_mix";
        alt_mode  = 1'b1;
        for (int i = 0; i < 40; i++) begin
            issue(($urandom % 4) != 0, rdreq_pkg::len_t'(4 * (($urandom % 512) + 1)),
                  ($urandom % 4) != 0, rdreq_pkg::len_t'(4 * (($urandom % 512) + 1)));
            wait_drain();
        end

        repeat (20) @(negedge clk);   // room for a stray beat
        $display("TEST PASS");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // monitor checks each tx beat against its channel queue
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin : monitor
        rdreq_pkg::rd_hdr_t act;
        rdreq_pkg::rd_hdr_t exp;
        logic               ch;
        logic               busy_exp;
        logic               busy_act;
        logic               other_pending;
        if (!rst && tx_valid) begin
            act = tx_data.hdr;          // header view of the raw beat
            ch  = act.addr_hi[31];
            if ((ch && exp_q1.size() == 0) || (!ch && exp_q0.size() == 0)) begin
                $display("beat from channel %0d arrived with nothing queued for it", ch);
                fail_run();
            end else begin
                if (ch) begin
                    exp           = exp_q1.pop_front();
                    busy_exp      = (exp_q1.size() != 0);   // busy drops with last beat
                    busy_act      = cmd1_busy;
                    other_pending = (exp_q0.size() != 0);
                end else begin
                    exp           = exp_q0.pop_front();
                    busy_exp      = (exp_q0.size() != 0);
                    busy_act      = cmd0_busy;
                    other_pending = (exp_q1.size() != 0);
                end
                exp.tag = exp_tag;
                check_flag("sop", 1'b1, tx_sop);
                check_flag("eop", 1'b1, tx_eop);
                check_tag(exp_tag, act.tag);
                check_hdr(exp, act);
                check_flag("busy", busy_exp, busy_act);
                if (alt_mode && have_prev && other_pending) begin
                    check_flag("channel", ~prev_ch, ch);   // strict turn taking
                end
                prev_ch   = ch;
                have_prev = 1'b1;
                exp_tag   = exp_tag + rdreq_pkg::tag_t'(1);   // wraps at 32
            end
        end
    end

    // watchdog allows 8 cycles per queued beat plus 200
    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles > 8 * beats_planned + 200) begin
            $display("timeout after %0d cycles, %0d beats never arrived", wd_cycles,
                     exp_q0.size() + exp_q1.size());
            fail_run();
        end
    end

endmodule

// ==== pcie_rdreq.f ====
+incdir+verif
src/rdreq_pkg.sv
src/rdreq_ifs.sv
src/chn_req.sv
src/chn_arb.sv
src/tx_mux.sv
src/pcie_rdreq_top.sv
verif/tb_pcie_rdreq.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the read request testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_pcie_rdreq -f pcie_rdreq.f \
    --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_pcie_rdreq > sim.log 2>&1
status=$?

# log decides, exit status only catches a crash
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi
echo "simulation passed"
exit 0
